/* vlog.f */
+incdir+include
rtl/elink_pkg.sv
rtl/link_tx.sv
rtl/link_rx.sv
rtl/link_ctrl.sv
rtl/mem_target.sv
rtl/elink_loop_top.sv
verif/elink_loop_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the loopback testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module elink_loop_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/Velink_loop_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Testbench run ended with status $status"
   exit $status
fi

exit 0

/* verif/elink_loop_tb.sv */
`default_nettype none

`include "elink_defs.svh"

module elink_loop_tb;

   localparam int CLK_PERIOD = 20;
   localparam int N_OPS      = 300;
   localparam int OP_CYCLES  = 40;  // Watchdog budget per operation
   localparam int WR_BUSY    = 14;  // wr_wait high cycles after a take
   localparam int RD_TRIP    = 29;  // Read take to out_access

   logic               clkin = 1'b0;
   logic               reset;
   logic               ext_access;
   elink_pkg::packet_t ext_packet;
   logic               rd_wait;
   logic               wr_wait;
   logic               out_access;
   elink_pkg::packet_t out_packet;

   logic [31:0]        model_mem [`ELINK_MEM_WORDS];  // Word image of the target
   elink_pkg::packet_t exp_rsp;   // Single expected-response slot
   bit                 rd_pend;   // Read in flight
   int                 rd_age;    // Cycles since that read was taken
   int                 wr_left;   // Local transmitter busy cycles left
   bit                 exp_wr;
   bit                 exp_rd;
   bit                 exp_out;
   int                 n_reads;
   int                 n_writes;
   int                 n_ignored;

   elink_loop_top dut_i (
      .clkin      (clkin),
      .reset      (reset),
      .ext_access (ext_access),
      .ext_packet (ext_packet),
      .rd_wait    (rd_wait),
      .wr_wait    (wr_wait),
      .out_access (out_access),
      .out_packet (out_packet)
   );

   always #(CLK_PERIOD / 2) clkin = ~clkin;

   task automatic stop_on_failure();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_error(input string msg);
      $display("[ERROR] %0t: %s", $time, msg);
      stop_on_failure();
   endtask

   // Drive for one clock and check at the next falling edge
   task automatic tick(input logic acc, input elink_pkg::packet_t pkt);
      bit is_wr;
      bit taken;
      is_wr      = pkt.ctrl[1];
      taken      = acc && (is_wr ? !exp_wr : !exp_rd);  // Wait low at the edge
      ext_access = acc;
      ext_packet = pkt;
      @(negedge clkin);
      if (taken) begin
         wr_left = WR_BUSY;
         if (is_wr) begin
            model_mem[pkt.dst_addr[5:2]] = pkt.data;  // Word index wraps at 16
            n_writes++;
         end else begin
            exp_rsp.src_addr = pkt.dst_addr;
            exp_rsp.data     = model_mem[pkt.dst_addr[5:2]];
            exp_rsp.dst_addr = pkt.src_addr;
            rd_pend          = 1'b1;
            rd_age           = 0;
            n_reads++;
         end
      end else if (acc) begin
         n_ignored++;  // Dropped with the model untouched
      end
      if (rd_pend) rd_age++;
      exp_out = rd_pend && (rd_age == RD_TRIP);
      exp_wr  = (wr_left > 0);
      exp_rd  = exp_wr || rd_pend;
      assert (wr_wait === exp_wr)
         else report_error($sformatf("wr_wait is %b, expected %b", wr_wait, exp_wr));
      assert (rd_wait === exp_rd)
         else report_error($sformatf("rd_wait is %b, expected %b", rd_wait, exp_rd));
      assert (out_access === exp_out)
         else report_error($sformatf("out_access is %b, expected %b", out_access, exp_out));
      if (exp_out) begin
         assert (out_packet.data === exp_rsp.data)
            else report_error($sformatf("read data %h, expected %h",
                                        out_packet.data, exp_rsp.data));
         assert (out_packet.dst_addr === exp_rsp.dst_addr &&
                 out_packet.src_addr === exp_rsp.src_addr && out_packet.ctrl[1] === 1'b1)
            else report_error($sformatf("response header dst %h src %h ctrl %h is wrong",
                              out_packet.dst_addr, out_packet.src_addr, out_packet.ctrl));
         rd_pend = 1'b0;  // rd_wait drops one cycle later
      end
      if (wr_left > 0) wr_left--;
   endtask

   function automatic elink_pkg::packet_t make_packet(input bit is_wr, input logic [5:0] word);
      elink_pkg::packet_t p;
      p.src_addr = $urandom();
      p.data     = $urandom();
      p.dst_addr = {24'h0, word, 2'b00};  // 64-word span where bits 7:6 alias
      p.ctrl     = 8'($urandom());
      p.ctrl[1]  = is_wr;
      return p;
   endfunction

   // Only polite requests hold off until their wait drops
   task automatic send_op(input bit is_wr, input logic [5:0] word, input bit polite);
      elink_pkg::packet_t pkt;
      int                 gap;
      pkt = make_packet(is_wr, word);
      if (polite) begin
         while (is_wr ? exp_wr : exp_rd) tick(1'b0, pkt);
      end
      tick(1'b1, pkt);
      gap = $urandom_range(0, 3);
      repeat (gap) tick(1'b0, pkt);
   endtask

   initial begin
      bit          is_wr;
      bit          polite;
      logic [5:0]  word;
      int unsigned r;
      void'($urandom(10));
      reset      = 1'b1;
      ext_access = 1'b0;
      ext_packet = '0;
      exp_rsp    = '0;
      for (int i = 0; i < `ELINK_MEM_WORDS; i++) model_mem[i] = '0;
      repeat (3) @(negedge clkin);
      reset = 1'b0;
      assert (!out_access && !rd_wait && !wr_wait)
         else report_error("outputs not all low after reset");
      send_op(1'b0, 6'd3, 1'b1);   // Unwritten word reads 0
      send_op(1'b1, 6'd5, 1'b1);
      send_op(1'b0, 6'd21, 1'b1);  // Alias of word 5
      for (int i = 0; i < N_OPS; i++) begin
         r      = $urandom();
         is_wr  = r[0];
         polite = (r[3:2] != 2'b00);
         word   = r[9:4];
         send_op(is_wr, word, polite);
      end
      while (rd_pend || wr_left > 0) tick(1'b0, ext_packet);  // Drain
      repeat (5) tick(1'b0, ext_packet);  // No stray responses
      $display("Reads %0d, writes %0d, ignored %0d", n_reads, n_writes, n_ignored);
      $display("Simulation passed");
      $finish;
   end

   initial begin
      #(N_OPS * OP_CYCLES * CLK_PERIOD);
      $display("Watchdog expired: the run did not finish in time");
      stop_on_failure();
   end

endmodule

`default_nettype wire

/* rtl/elink_loop_top.sv */
`default_nettype none

module elink_loop_top (
   input  wire logic               clkin,
   input  wire logic               reset,
   input  wire logic               ext_access,
   input  wire elink_pkg::packet_t ext_packet,
   output logic                    rd_wait,
   output logic                    wr_wait,
   output logic                    out_access,  // Read response out
   output elink_pkg::packet_t      out_packet
);

   logic               tx_access;    // Admitted request
   elink_pkg::packet_t tx_packet;
   logic               tx_busy;
   logic               req_frame;    // Local to remote lane
   logic [7:0]         req_data;
   logic               rx_access;    // Request at remote end
   elink_pkg::packet_t rx_packet;
   logic               rsp_access;   // Read response from memory
   elink_pkg::packet_t rsp_packet;
   logic               rsp_frame;    // Remote to local lane
   logic [7:0]         rsp_data;

   link_ctrl ctrl_i (
      .clkin      (clkin),
      .reset      (reset),
      .ext_access (ext_access),
      .ext_packet (ext_packet),
      .tx_busy    (tx_busy),
      .rsp_done   (out_access),  // Response arrival closes the read
      .tx_access  (tx_access),
      .tx_packet  (tx_packet),
      .rd_wait    (rd_wait),
      .wr_wait    (wr_wait)
   );

   link_tx tx_local (
      .clkin  (clkin),
      .reset  (reset),
      .access (tx_access),
      .packet (tx_packet),
      .busy   (tx_busy),
      .frame  (req_frame),
      .data   (req_data)
   );

   link_rx rx_remote (
      .clkin  (clkin),
      .reset  (reset),
      .frame  (req_frame),
      .data   (req_data),
      .access (rx_access),
      .packet (rx_packet)
   );

   mem_target mem_i (
      .clkin      (clkin),
      .reset      (reset),
      .req_access (rx_access),
      .req_packet (rx_packet),
      .rsp_access (rsp_access),
      .rsp_packet (rsp_packet)
   );

   link_tx tx_remote (
      .clkin  (clkin),
      .reset  (reset),
      .access (rsp_access),
      .packet (rsp_packet),
      .busy   (),  // Idle whenever a response arrives, one read in flight
      .frame  (rsp_frame),
      .data   (rsp_data)
   );

   link_rx rx_local (
      .clkin  (clkin),
      .reset  (reset),
      .frame  (rsp_frame),
      .data   (rsp_data),
      .access (out_access),
      .packet (out_packet)
   );

endmodule

`default_nettype wire

/* rtl/mem_target.sv */
`default_nettype none

`include "elink_defs.svh"

module mem_target (
   input  wire logic               clkin,
   input  wire logic               reset,
   input  wire logic               req_access,
   input  wire elink_pkg::packet_t req_packet,
   output logic                    rsp_access,  // Read response valid
   output elink_pkg::packet_t      rsp_packet
);

   logic [31:0]              mem [`ELINK_MEM_WORDS];
   logic [`ELINK_MEM_AW-1:0] idx;  // Wraps every 16 words
   elink_pkg::opcode_e       op;

   assign idx = req_packet.dst_addr[`ELINK_MEM_AW+1:2];
   assign op  = elink_pkg::opcode_e'(req_packet.ctrl[1]);

   // Word storage, cleared so unwritten reads return 0
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < `ELINK_MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (req_access && op == elink_pkg::OP_WRITE) begin
         mem[idx] <= req_packet.data;
      end
   end

   // Response strobe
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         rsp_access <= 1'b0;
      end else begin
         rsp_access <= req_access && op == elink_pkg::OP_READ;
      end
   end

   // Response goes back as a write to the requester
   always_ff @(posedge clkin) begin
      if (req_access && op == elink_pkg::OP_READ) begin
         rsp_packet.src_addr <= req_packet.dst_addr;
         rsp_packet.data     <= mem[idx];
         rsp_packet.dst_addr <= req_packet.src_addr;
         rsp_packet.ctrl     <= {req_packet.ctrl[7:2], elink_pkg::OP_WRITE,
                                 req_packet.ctrl[0]};  // Set write flag
      end
   end

endmodule

`default_nettype wire

/* rtl/link_ctrl.sv */
`default_nettype none

module link_ctrl (
   input  wire logic               clkin,
   input  wire logic               reset,
   input  wire logic               ext_access,
   input  wire elink_pkg::packet_t ext_packet,
   input  wire logic               tx_busy,   // Local transmitter framing
   input  wire logic               rsp_done,  // Read response back at local end
   output logic                    tx_access,
   output elink_pkg::packet_t      tx_packet,
   output logic                    rd_wait,
   output logic                    wr_wait
);

   elink_pkg::ctrl_state_e state;
   elink_pkg::ctrl_state_e state_next;
   elink_pkg::opcode_e     op;
   logic                   admit;  // Request taken this edge

   assign op    = elink_pkg::opcode_e'(ext_packet.ctrl[1]);
   assign admit = ext_access &&
                  ((op == elink_pkg::OP_WRITE) ? !wr_wait : !rd_wait);

   assign tx_access = admit;       // Transmitter loads on the same edge
   assign tx_packet = ext_packet;

   // Next state
   always_comb begin
      state_next = state;
      case (state)
         elink_pkg::IDLE: begin
            if (admit) begin
               state_next = (op == elink_pkg::OP_READ) ? elink_pkg::READ_PEND
                                                       : elink_pkg::SEND;
            end
         end
         elink_pkg::SEND: begin
            if (!tx_busy) state_next = elink_pkg::IDLE;  // Write fully sent
         end
         elink_pkg::READ_PEND: begin
            if (rsp_done) state_next = elink_pkg::IDLE;  // Writes may pass meanwhile
         end
         default: state_next = elink_pkg::IDLE;
      endcase
   end

   // State and registered waits
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         state   <= elink_pkg::IDLE;
         rd_wait <= 1'b0;
         wr_wait <= 1'b0;
      end else begin
         state   <= state_next;
         wr_wait <= admit || tx_busy;  // Covers the cycle busy rises
         rd_wait <= admit || tx_busy || (state_next == elink_pkg::READ_PEND);
      end
   end

   // Registered waits must stay ahead of the transmitter
   a_no_admit_busy: assert property (@(posedge clkin) disable iff (reset)
      admit |-> !tx_busy);

   // Responses only come back for a pending read
   a_rsp_pending: assert property (@(posedge clkin) disable iff (reset)
      rsp_done |-> state == elink_pkg::READ_PEND);

endmodule

`default_nettype wire

/* rtl/link_rx.sv */
`default_nettype none

`include "elink_defs.svh"

module link_rx (
   input  wire logic          clkin,
   input  wire logic          reset,
   input  wire logic          frame,
   input  wire logic [7:0]    data,
   output logic               access,  // One-cycle pulse after last byte
   output elink_pkg::packet_t packet
);

   localparam int CW = $clog2(`ELINK_PKT_BYTES + 1);

   logic [CW-1:0]           cnt;    // Bytes taken in this frame
   logic [`ELINK_PKT_W-1:0] shreg;  // Assembly register

   assign packet = elink_pkg::packet_t'(shreg);  // Stable during access

   // Byte count and access pulse
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         cnt    <= '0;
         access <= 1'b0;
      end else if (frame) begin
         cnt    <= cnt + 1'b1;
         access <= (cnt == CW'(`ELINK_PKT_BYTES - 1));  // 13th byte now
      end else begin
         cnt    <= '0;  // Resync on every gap
         access <= 1'b0;
      end
   end

   // Low byte arrives first, so shift in from the top
   always_ff @(posedge clkin) begin
      if (frame) begin
         shreg <= {data, shreg[`ELINK_PKT_W-1:8]};
      end
   end

   // A frame only ends after a full packet
   a_frame_whole: assert property (@(posedge clkin) disable iff (reset)
      $fell(frame) |-> cnt == CW'(`ELINK_PKT_BYTES));

endmodule

`default_nettype wire

/* rtl/link_tx.sv */
`default_nettype none

`include "elink_defs.svh"

module link_tx (
   input  wire logic               clkin,
   input  wire logic               reset,
   input  wire logic               access,  // Load a packet, only when idle
   input  wire elink_pkg::packet_t packet,
   output logic                    busy,
   output logic                    frame,   // High for all 13 bytes
   output logic [7:0]              data     // Low byte first
);

   localparam int CW = $clog2(`ELINK_PKT_BYTES + 1);

   logic [CW-1:0]           cnt;    // Bytes already driven onto the lane
   logic [`ELINK_PKT_W-1:0] shreg;  // Bytes still to go

   assign busy = frame;  // Busy exactly while framing

   // Frame and byte counter
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         frame <= 1'b0;
         cnt   <= '0;
      end else if (access) begin
         frame <= 1'b1;  // First byte goes out next cycle
         cnt   <= CW'(1);
      end else if (frame) begin
         if (cnt == CW'(`ELINK_PKT_BYTES)) begin
            frame <= 1'b0;  // Gives at least one idle cycle
            cnt   <= '0;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // Byte shifter
   always_ff @(posedge clkin) begin
      if (access) begin
         data  <= packet[7:0];
         shreg <= packet >> 8;
      end else if (frame) begin
         data  <= shreg[7:0];
         shreg <= shreg >> 8;
      end
   end

   // Upstream must honour busy through its registered waits
   a_no_access_busy: assert property (@(posedge clkin) disable iff (reset)
      access |-> !busy);

endmodule

`default_nettype wire

/* rtl/elink_pkg.sv */
`default_nettype none

package elink_pkg;

   // Opcode lives in ctrl bit 1
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } opcode_e;

   // Request control FSM
   typedef enum logic [1:0] {
      IDLE      = 2'd0,  // Nothing in flight
      SEND      = 2'd1,  // Write on the local lane
      READ_PEND = 2'd2   // Waiting for read response
   } ctrl_state_e;

   // 104-bit transaction, MSB field first
   typedef struct packed {
      logic [31:0] src_addr;  // Return address for reads
      logic [31:0] data;      // Write data or read data
      logic [31:0] dst_addr;  // Target address
      logic [7:0]  ctrl;      // Bit 1 is the write flag
   } packet_t;

endpackage

`default_nettype wire

/* include/elink_defs.svh */
`ifndef ELINK_DEFS_SVH
`define ELINK_DEFS_SVH

// Link packet geometry
`define ELINK_PKT_W      104  // Full transaction packet
`define ELINK_PKT_BYTES  13   // Bytes per frame on a lane

// Remote memory target
`define ELINK_MEM_WORDS  16   // 32-bit words
`define ELINK_MEM_AW     4    // Word index, taken from dst_addr[5:2]

`endif
